/* hw/isa_pkg.sv */
package isa_pkg;

        localparam int IMEM_DEPTH_LOG2 = 6;     // 64 instruction words
        localparam int DMEM_DEPTH_LOG2 = 6;     // 64 data words

        typedef logic [31:0] word_t;            // data and instruction word
        typedef logic [4:0]  reg_idx_t;         // r0 to r31

        // major opcodes of the supported subset
        typedef enum logic [5:0] {
                op_rtype = 6'h00,
                op_j     = 6'h02,
                op_beq   = 6'h04,
                op_addi  = 6'h08,
                op_lw    = 6'h23,
                op_sw    = 6'h2b
        } opcode_t;

        // function field of r-type words
        typedef enum logic [5:0] {
                fn_add = 6'h20,
                fn_sub = 6'h22,
                fn_and = 6'h24,
                fn_or  = 6'h25,
                fn_slt = 6'h2a
        } funct_t;

        typedef struct packed {
                opcode_t    opcode;
                reg_idx_t   rs;
                reg_idx_t   rt;
                reg_idx_t   rd;
                logic [4:0] shamt;              // unused by this subset
                funct_t     funct;
        } r_fmt_t;

        // j reuses rs, rt and imm as its 26-bit target
        typedef struct packed {
                opcode_t     opcode;
                reg_idx_t    rs;
                reg_idx_t    rt;
                logic [15:0] imm;
        } i_fmt_t;

        typedef union packed {
                r_fmt_t r;
                i_fmt_t i;
        } instr_u;

endpackage

/* hw/pipe_pkg.sv */
package pipe_pkg;

        import isa_pkg::*;

        typedef enum logic [2:0] {
                alu_add,
                alu_sub,
                alu_and,
                alu_or,
                alu_slt
        } alu_op_t;

        // operand source in EX
        typedef enum logic [1:0] {
                fwd_none,                       // value read in decode
                fwd_mem,                        // EX/MEM result
                fwd_wb                          // write-back value
        } fwd_sel_t;

        typedef struct packed {
                logic        valid;
                word_t       pc;
                reg_idx_t    rs;
                reg_idx_t    rt;
                reg_idx_t    dest;
                word_t       rs_val;
                word_t       rt_val;
                word_t       imm;               // sign extended
                alu_op_t     alu_op;
                logic        use_imm;
                logic        reg_write;
                logic        mem_read;
                logic        mem_write;
                logic        is_beq;
                logic        is_j;
                logic [25:0] jtarget;
        } id_ex_t;

        typedef struct packed {
                logic     valid;
                word_t    result;               // alu result or byte address
                word_t    store_data;
                reg_idx_t dest;
                logic     reg_write;
                logic     mem_read;
                logic     mem_write;
        } ex_mem_t;

        // MEM/WB record, also the register file write port
        typedef struct packed {
                logic     valid;
                reg_idx_t dest;
                word_t    data;
                logic     reg_write;
        } wb_t;

        typedef struct packed {
                logic                       we;
                logic [IMEM_DEPTH_LOG2-1:0] addr;       // word address
                word_t                      data;
        } imem_load_t;

        typedef struct packed {
                logic     valid;
                reg_idx_t rd;
                word_t    data;
        } commit_t;

        typedef struct packed {
                logic  valid;
                word_t addr;                    // byte address
                word_t data;
        } store_t;

        typedef struct packed {
                logic  taken;
                word_t target;
        } redirect_t;

endpackage

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import isa_pkg::*, pipe_pkg::*; (
        input  logic       clk,
        input  logic       rst_n,
        input  logic       run,
        input  imem_load_t imem_load,
        input  logic       stall,
        input  logic       flush,
        input  redirect_t  redirect,
        output word_t      if_instr,
        output word_t      if_pc,
        output logic       if_valid
);

        word_t pc;                              // address being fetched
        word_t imem [2**IMEM_DEPTH_LOG2];
        word_t fetched;

        // program load only while parked
        always_ff @(posedge clk) begin
                if (imem_load.we && !run)
                        imem[imem_load.addr] <= imem_load.data;
        end

        assign fetched = imem[pc[IMEM_DEPTH_LOG2+1:2]];         // byte pc to word index

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        pc <= '0;
                else if (!run)
                        pc <= '0;                       // held at reset vector
                else if (redirect.taken)
                        pc <= redirect.target;          // resolved in EX
                else if (!stall)
                        pc <= pc + 32'd4;
        end

        // IF/ID register
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        if_instr <= '0;
                        if_pc    <= '0;
                        if_valid <= 1'b0;
                end else if (!run || flush) begin
                        if_valid <= 1'b0;               // squash wrong-path word
                end else if (!stall) begin
                        if_instr <= fetched;
                        if_pc    <= pc;
                        if_valid <= 1'b1;
                end
        end

        // loader and running pipeline never overlap
        a_no_load_while_run: assert property (@(posedge clk) disable iff (!rst_n)
                imem_load.we |-> !run);

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
        input  logic     clk,
        input  logic     rst_n,
        input  word_t    if_instr,
        input  word_t    if_pc,
        input  logic     if_valid,
        input  logic     stall,
        input  logic     flush,
        input  wb_t      wb,
        output id_ex_t   id_ex,
        output reg_idx_t id_rs,
        output reg_idx_t id_rt
);

        instr_u ins;
        word_t  regs [32];
        logic   wb_we;                          // real register write this cycle
        logic   known;                          // encoding in the subset
        id_ex_t dec;

        assign ins   = if_instr;
        assign id_rs = ins.i.rs;                // raw fields to hazard check
        assign id_rt = ins.i.rt;
        assign wb_we = wb.valid && wb.reg_write && (wb.dest != '0);

        // register file, r0 never written
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int k = 0; k < 32; k++)
                                regs[k] <= '0;
                end else if (wb_we) begin
                        regs[wb.dest] <= wb.data;
                end
        end

        always_comb begin
                dec         = '0;
                known       = 1'b1;
                dec.pc      = if_pc;
                dec.rs      = ins.i.rs;
                dec.rt      = ins.i.rt;
                // write-back in the same cycle wins over the stored value
                dec.rs_val  = (wb_we && wb.dest == ins.i.rs) ? wb.data : regs[ins.i.rs];
                dec.rt_val  = (wb_we && wb.dest == ins.i.rt) ? wb.data : regs[ins.i.rt];
                dec.imm     = {{16{ins.i.imm[15]}}, ins.i.imm};
                dec.jtarget = {ins.i.rs, ins.i.rt, ins.i.imm};
                dec.alu_op  = alu_add;          // default for addr calc
                case (ins.i.opcode)
                        op_rtype: begin
                                dec.dest      = ins.r.rd;
                                dec.reg_write = 1'b1;
                                case (ins.r.funct)
                                        fn_add:  dec.alu_op = alu_add;
                                        fn_sub:  dec.alu_op = alu_sub;
                                        fn_and:  dec.alu_op = alu_and;
                                        fn_or:   dec.alu_op = alu_or;
                                        fn_slt:  dec.alu_op = alu_slt;
                                        default: known = 1'b0;
                                endcase
                        end
                        op_addi: begin
                                dec.dest      = ins.i.rt;
                                dec.reg_write = 1'b1;
                                dec.use_imm   = 1'b1;
                        end
                        op_lw: begin
                                dec.dest      = ins.i.rt;
                                dec.reg_write = 1'b1;
                                dec.use_imm   = 1'b1;
                                dec.mem_read  = 1'b1;
                        end
                        op_sw: begin
                                dec.use_imm   = 1'b1;
                                dec.mem_write = 1'b1;
                        end
                        op_beq:  dec.is_beq = 1'b1;     // compare done in EX
                        op_j:    dec.is_j   = 1'b1;
                        default: known = 1'b0;
                endcase
                if (dec.dest == '0)
                        dec.reg_write = 1'b0;   // r0 writes vanish here
                dec.valid = if_valid;
                if (!known)
                        dec = '0;               // unknown word becomes a bubble
        end

        // ID/EX register
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        id_ex <= '0;
                else if (stall || flush)
                        id_ex <= '0;            // bubble
                else
                        id_ex <= dec;
        end

        // r0 filtering in decode must survive EX and MEM
        a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
                (wb.valid && wb.reg_write) |-> (wb.dest != '0));

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
        input  logic      clk,
        input  logic      rst_n,
        input  id_ex_t    id_ex,
        input  fwd_sel_t  fwd_a,
        input  fwd_sel_t  fwd_b,
        input  word_t     mem_fwd,
        input  wb_t       wb,
        output ex_mem_t   ex_mem,
        output redirect_t redirect
);

        word_t a;                               // forwarded rs
        word_t b;                               // forwarded rt
        word_t alu_b;
        word_t result;
        word_t pc4;
        word_t br_target;
        word_t j_target;

        function automatic word_t pick(input fwd_sel_t sel, input word_t reg_val,
                                       input word_t mem_val, input word_t wb_val);
                case (sel)
                        fwd_mem: return mem_val;
                        fwd_wb:  return wb_val;
                        default: return reg_val;
                endcase
        endfunction

        assign a     = pick(fwd_a, id_ex.rs_val, mem_fwd, wb.data);
        assign b     = pick(fwd_b, id_ex.rt_val, mem_fwd, wb.data);
        assign alu_b = id_ex.use_imm ? id_ex.imm : b;   // addi, lw, sw

        always_comb begin
                case (id_ex.alu_op)
                        alu_sub: result = a - alu_b;
                        alu_and: result = a & alu_b;
                        alu_or:  result = a | alu_b;
                        alu_slt: result = {31'd0, $signed(a) < $signed(alu_b)};
                        default: result = a + alu_b;
                endcase
        end

        assign pc4       = id_ex.pc + 32'd4;
        assign br_target = pc4 + {id_ex.imm[29:0], 2'b00};
        assign j_target  = {pc4[31:28], id_ex.jtarget, 2'b00};    // keep region bits

        assign redirect.taken  = id_ex.valid && (id_ex.is_j || (id_ex.is_beq && a == b));
        assign redirect.target = id_ex.is_j ? j_target : br_target;

        // EX/MEM register
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        ex_mem <= '0;
                end else begin
                        ex_mem.valid      <= id_ex.valid;
                        ex_mem.result     <= result;
                        ex_mem.store_data <= b;         // forwarded rt for sw
                        ex_mem.dest       <= id_ex.dest;
                        ex_mem.reg_write  <= id_ex.reg_write;
                        ex_mem.mem_read   <= id_ex.mem_read;
                        ex_mem.mem_write  <= id_ex.mem_write;
                end
        end

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import isa_pkg::*, pipe_pkg::*; (
        input  logic    clk,
        input  logic    rst_n,
        input  ex_mem_t ex_mem,
        output wb_t     wb,
        output commit_t commit,
        output store_t  store
);

        word_t                      dmem [2**DMEM_DEPTH_LOG2];
        logic [DMEM_DEPTH_LOG2-1:0] word_idx;
        logic                       do_store;

        assign word_idx = ex_mem.result[DMEM_DEPTH_LOG2+1:2];  // word addressed
        assign do_store = ex_mem.valid && ex_mem.mem_write;

        always_ff @(posedge clk) begin
                if (do_store)
                        dmem[word_idx] <= ex_mem.store_data;
        end

        // store reported in the cycle it is performed
        assign store.valid = do_store;
        assign store.addr  = ex_mem.result;
        assign store.data  = ex_mem.store_data;

        // MEM/WB register with write-back select
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wb <= '0;
                end else begin
                        wb.valid     <= ex_mem.valid;
                        wb.dest      <= ex_mem.dest;
                        wb.reg_write <= ex_mem.reg_write;
                        wb.data      <= ex_mem.mem_read ? dmem[word_idx] : ex_mem.result;
                end
        end

        // one pulse per retired register write
        assign commit.valid = wb.valid && wb.reg_write && (wb.dest != '0);
        assign commit.rd    = wb.dest;
        assign commit.data  = wb.data;

endmodule

/* hw/pipe_ctrl.sv */
`timescale 1ns/1ps

module pipe_ctrl import isa_pkg::*, pipe_pkg::*; (
        input  logic     clk,                   // assertion sampling only
        input  logic     rst_n,
        input  reg_idx_t id_rs,
        input  reg_idx_t id_rt,
        input  id_ex_t   id_ex,
        input  ex_mem_t  ex_mem,
        input  wb_t      wb,
        input  logic     redirect_taken,
        output logic     stall,
        output logic     flush,
        output fwd_sel_t fwd_a,
        output fwd_sel_t fwd_b
);

        logic load_use;

        // nearest producer first, r0 is never forwarded
        function automatic fwd_sel_t pick(input reg_idx_t src, input ex_mem_t m, input wb_t w);
                if (src == '0)
                        return fwd_none;
                if (m.valid && m.reg_write && m.dest == src)
                        return fwd_mem;
                if (w.valid && w.reg_write && w.dest == src)
                        return fwd_wb;
                return fwd_none;
        endfunction

        // load in EX feeding the word in ID
        assign load_use = id_ex.valid && id_ex.mem_read && (id_ex.dest != '0) &&
                          (id_ex.dest == id_rs || id_ex.dest == id_rt);

        assign flush = redirect_taken;
        assign stall = load_use && !redirect_taken;     // flush has priority

        assign fwd_a = pick(id_ex.rs, ex_mem, wb);
        assign fwd_b = pick(id_ex.rt, ex_mem, wb);

        // the bubble behind a load always clears the hazard
        a_stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
                stall |=> !stall);

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import isa_pkg::*, pipe_pkg::*; (
        input  logic       clk,
        input  logic       rst_n,
        input  logic       run,
        input  imem_load_t imem_load,
        output commit_t    commit,
        output store_t     store
);

        word_t     if_instr;                    // IF/ID
        word_t     if_pc;
        logic      if_valid;
        id_ex_t    id_ex;
        reg_idx_t  id_rs;
        reg_idx_t  id_rt;
        ex_mem_t   ex_mem;
        wb_t       wb;                          // write-back bus
        redirect_t redirect;
        logic      stall;
        logic      flush;
        fwd_sel_t  fwd_a;
        fwd_sel_t  fwd_b;

        fetch_stage fetch_stage (
                .clk(clk), .rst_n(rst_n), .run(run), .imem_load(imem_load),
                .stall(stall), .flush(flush), .redirect(redirect),
                .if_instr(if_instr), .if_pc(if_pc), .if_valid(if_valid)
        );

        decode_stage decode_stage (
                .clk(clk), .rst_n(rst_n), .if_instr(if_instr), .if_pc(if_pc),
                .if_valid(if_valid), .stall(stall), .flush(flush), .wb(wb),
                .id_ex(id_ex), .id_rs(id_rs), .id_rt(id_rt)
        );

        execute_stage execute_stage (
                .clk(clk), .rst_n(rst_n), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
                .mem_fwd(ex_mem.result), .wb(wb), .ex_mem(ex_mem), .redirect(redirect)
        );

        mem_stage mem_stage (
                .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .wb(wb),
                .commit(commit), .store(store)
        );

        pipe_ctrl pipe_ctrl (
                .clk(clk), .rst_n(rst_n), .id_rs(id_rs), .id_rt(id_rt), .id_ex(id_ex),
                .ex_mem(ex_mem), .wb(wb), .redirect_taken(redirect.taken),
                .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
        );

endmodule

/* sim/tb_model.svh */
// instruction-level reference, knows nothing of pipeline timing
task automatic run_model();
        word_t   mregs [32];
        word_t   mmem [2**DMEM_DEPTH_LOG2];
        word_t   pc;
        word_t   pc4;
        word_t   next_pc;
        word_t   sext;
        word_t   addr;
        word_t   a;
        word_t   b;
        word_t   wr_val;
        reg_idx_t wr_idx;
        logic    wr_en;
        instr_u  w;
        commit_t cm;
        store_t  st;
        int      steps;
        logic    done;
        mregs = '{default: '0};
        mmem  = '{default: '0};         // every word read is written by the prologue first
        pc    = '0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < MODEL_STEPS) begin
                w       = prog[pc[IMEM_DEPTH_LOG2+1:2]];
                pc4     = pc + 32'd4;
                next_pc = pc4;
                sext    = {{16{w.i.imm[15]}}, w.i.imm};
                a       = mregs[w.i.rs];
                b       = mregs[w.i.rt];
                addr    = a + sext;             // lw and sw effective address
                wr_en   = 1'b0;
                wr_idx  = w.i.rt;               // i-type destination
                wr_val  = '0;
                case (w.i.opcode)
                        op_rtype: begin
                                wr_en  = 1'b1;
                                wr_idx = w.r.rd;
                                case (w.r.funct)
                                        fn_add:  wr_val = a + b;
                                        fn_sub:  wr_val = a - b;
                                        fn_and:  wr_val = a & b;
                                        fn_or:   wr_val = a | b;
                                        default: wr_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                                endcase
                        end
                        op_addi: begin
                                wr_en  = 1'b1;
                                wr_val = addr;
                        end
                        op_lw: begin
                                wr_en  = 1'b1;
                                wr_val = mmem[addr[DMEM_DEPTH_LOG2+1:2]];
                        end
                        op_sw: begin
                                mmem[addr[DMEM_DEPTH_LOG2+1:2]] = b;
                                st.valid = 1'b1;
                                st.addr  = addr;
                                st.data  = b;
                                exp_stores.push_back(st);
                        end
                        op_beq: begin
                                if (a == b)
                                        next_pc = pc4 + {sext[29:0], 2'b00};
                        end
                        op_j: begin
                                next_pc = {pc4[31:28], w.i.rs, w.i.rt, w.i.imm, 2'b00};
                                done    = (next_pc == pc);      // parking loop reached
                        end
                        default: wr_en = 1'b0;
                endcase
                if (wr_en && wr_idx != '0) begin        // r0 stays zero, no event
                        mregs[wr_idx] = wr_val;
                        cm.valid = 1'b1;
                        cm.rd    = wr_idx;
                        cm.data  = wr_val;
                        exp_commits.push_back(cm);
                end
                pc = next_pc;
                steps++;
        end
        if (!done) begin
                $display("reference model never reached the final self jump");
                stop_with_failure();
        end
endtask

/* sim/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu import isa_pkg::*, pipe_pkg::*;;

        localparam int PROG_LEN     = 2**IMEM_DEPTH_LOG2;       // program fills imem
        localparam int BODY_START   = 31;                       // after 15 addi and 16 sw
        localparam int END_IDX      = PROG_LEN - 1;             // self jump
        localparam int MODEL_STEPS  = 1000;
        localparam int RUN_LIMIT    = 3000;                     // cycles to drain queues
        localparam int QUIET_CYCLES = 50;

        logic        clk;
        logic        rst_n;
        logic        run;
        imem_load_t  imem_load;
        commit_t     commit;
        store_t      store;

        word_t       prog [PROG_LEN];
        commit_t     exp_commits [$];                           // model order
        store_t      exp_stores [$];
        logic [31:0] lcg_state;

        cpu_top uut (
                .clk(clk), .rst_n(rst_n), .run(run), .imem_load(imem_load),
                .commit(commit), .store(store)
        );

        always #5 clk = ~clk;                                   // 10 ns period

        task automatic stop_with_failure();
                $display("SIMULATION FAILED");
                $fatal(1, "stopped at the first failure");
        endtask

        function automatic logic [31:0] rand_word();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        // upper half since low lcg bits cycle too fast
        function automatic int rand_below(input int n);
                return int'(rand_word() >> 16) % n;
        endfunction

        function automatic reg_idx_t rand_reg();
                return reg_idx_t'(rand_below(16));              // r0 to r15 for dense hazards
        endfunction

        function automatic word_t rtype_word(input funct_t fn, input reg_idx_t rd,
                                             input reg_idx_t rs, input reg_idx_t rt);
                instr_u w;
                w          = '0;
                w.r.opcode = op_rtype;
                w.r.rs     = rs;
                w.r.rt     = rt;
                w.r.rd     = rd;
                w.r.funct  = fn;
                return w;
        endfunction

        function automatic word_t itype_word(input opcode_t op, input reg_idx_t rs,
                                             input reg_idx_t rt, input logic [15:0] imm);
                instr_u w;
                w          = '0;
                w.i.opcode = op;
                w.i.rs     = rs;
                w.i.rt     = rt;
                w.i.imm    = imm;
                return w;
        endfunction

        function automatic word_t jump_word(input int target_idx);
                instr_u w;
                w          = '0;
                w.i.opcode = op_j;
                {w.i.rs, w.i.rt, w.i.imm} = 26'(target_idx);   // target is a word index
                return w;
        endfunction

        task automatic build_program();
                funct_t   fns [5];
                reg_idx_t rd;
                reg_idx_t rs;
                reg_idx_t rt;
                int       sel;
                int       skip;
                fns = '{fn_add, fn_sub, fn_and, fn_or, fn_slt};
                for (int k = 1; k <= 15; k++)                   // seed r1..r15
                        prog[k - 1] = itype_word(op_addi, 5'd0, 5'(k), 16'(rand_word() >> 16));
                for (int k = 0; k <= 15; k++)                   // words 0..15 at bytes 0..60
                        prog[15 + k] = itype_word(op_sw, 5'd0, 5'(k), 16'(4 * k));
                for (int k = BODY_START; k < END_IDX; k++) begin
                        sel  = rand_below(10);
                        rd   = rand_reg();
                        rs   = rand_reg();
                        rt   = rand_reg();
                        skip = 1 + rand_below(3);               // instructions jumped over
                        if (sel >= 8 && k + 1 + skip > END_IDX)
                                sel = 0;                        // no room to branch forward
                        case (sel)
                                4:       prog[k] = itype_word(op_addi, rs, rd,
                                                              16'(rand_word() >> 16));
                                5, 6:    prog[k] = itype_word(op_lw, 5'd0, rd,
                                                              16'(4 * rand_below(16)));
                                7:       prog[k] = itype_word(op_sw, 5'd0, rt,
                                                              16'(4 * rand_below(16)));
                                8: begin
                                        if (rand_below(2) == 0)
                                                rt = rs;        // force a taken branch
                                        prog[k] = itype_word(op_beq, rs, rt, 16'(skip));
                                end
                                9:       prog[k] = jump_word(k + 1 + skip);
                                default: prog[k] = rtype_word(fns[rand_below(5)], rd, rs, rt);
                        endcase
                end
                prog[END_IDX] = jump_word(END_IDX);             // park here
        endtask

        `include "tb_model.svh"

        task automatic load_program();
                for (int k = 0; k < PROG_LEN; k++) begin
                        @(posedge clk);
                        #1;
                        imem_load.we   = 1'b1;
                        imem_load.addr = IMEM_DEPTH_LOG2'(k);
                        imem_load.data = prog[k];
                end
                @(posedge clk);
                #1;
                imem_load = '0;
        endtask

        task automatic check_commit(input commit_t got);
                commit_t exp;
                if (exp_commits.size() == 0) begin
                        $display("ERROR at %0t: commit r%0d = %h with none expected",
                                 $time, got.rd, got.data);
                        stop_with_failure();
                end else begin
                        exp = exp_commits.pop_front();
                        if (got !== exp) begin
                                $display("ERROR at %0t: commit r%0d = %h, expected r%0d = %h",
                                         $time, got.rd, got.data, exp.rd, exp.data);
                                stop_with_failure();
                        end
                end
        endtask

        task automatic check_store(input store_t got);
                store_t exp;
                if (exp_stores.size() == 0) begin
                        $display("ERROR at %0t: store [%h] = %h with none expected",
                                 $time, got.addr, got.data);
                        stop_with_failure();
                end else begin
                        exp = exp_stores.pop_front();
                        if (got !== exp) begin
                                $display("ERROR at %0t: store [%h] = %h, expected [%h] = %h",
                                         $time, got.addr, got.data, exp.addr, exp.data);
                                stop_with_failure();
                        end
                end
        endtask

        // outputs come from stage registers and settle before the falling edge
        always @(negedge clk) begin
                if (rst_n) begin
                        if (!run && (commit.valid || store.valid)) begin
                                $display("core produced an output event at %0t while parked",
                                         $time);
                                stop_with_failure();
                        end else begin
                                if (commit.valid)
                                        check_commit(commit);
                                if (store.valid)
                                        check_store(store);
                        end
                end
        end

        initial begin
                int cycles;
                clk       = 1'b0;
                rst_n     = 1'b0;
                run       = 1'b0;
                imem_load = '0;
                lcg_state = 32'h1345;
                build_program();
                run_model();
                repeat (5) @(posedge clk);
                #1;
                rst_n = 1'b1;
                load_program();
                repeat (3) @(posedge clk);                      // parked core must stay silent
                #1;
                run    = 1'b1;
                cycles = 0;
                while ((exp_commits.size() != 0 || exp_stores.size() != 0) &&
                       cycles < RUN_LIMIT) begin
                        @(posedge clk);
                        cycles++;
                end
                if (exp_commits.size() != 0 || exp_stores.size() != 0) begin
                        $display("timeout: %0d commits and %0d stores missing after %0d cycles",
                                 exp_commits.size(), exp_stores.size(), RUN_LIMIT);
                        stop_with_failure();
                end else begin
                        for (int n = 0; n < QUIET_CYCLES; n++)  // monitor flags any extra event
                                @(posedge clk);
                        $display("SIMULATION PASSED");
                        $finish;
                end
        end

endmodule

/* vlog.f */
+incdir+sim
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/pipe_ctrl.sv
hw/cpu_top.sv
sim/tb_cpu.sv

/* Makefile */
TOP = tb_cpu

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and look for the pass message"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
